//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
TOP        ?= csr_unit_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
logic/csr_pkg.sv
logic/csr_issue.sv
logic/csr_file.sv
logic/csr_timer.sv
logic/csr_unit.sv
verif/csr_unit_tb.sv

//--- logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic               clk,
    input  logic               rstn,
    input  logic               commit_run,
    input  logic               stall,
    input  logic [4:0]         commit_mode,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_word_t commit_data,
    input  logic [5:0]         commit_ecode,
    input  logic [8:0]         commit_esubcode,
    input  csr_pkg::csr_word_t commit_pc,
    input  csr_pkg::csr_word_t commit_vaddr,
    input  logic [8:0]         hw_int,
    input  csr_pkg::csr_word_t tcfg,
    input  csr_pkg::csr_word_t tval,
    input  logic               timer_int,
    input  csr_pkg::csr_addr_t read_addr,
    output csr_pkg::csr_word_t read_data,
    output logic               int_pending,
    output csr_pkg::csr_word_t era,
    output csr_pkg::csr_word_t eentry,
    output csr_pkg::csr_word_t tlbrentry,
    output logic [8:0]         crmd,
    output logic               excp_flush,
    output logic               ertn_flush,
    output logic [5:0]         ecode,
    output logic               tcfg_we,
    output csr_pkg::csr_word_t tcfg_wdata,
    output logic               ticlr_pulse
);
    import csr_pkg::*;

    logic [2:0]  prmd;
    logic        euen;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_is;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    csr_word_t   badv;
    logic [31:6] eentry_q;
    logic [31:6] tlbrentry_q;
    csr_word_t   save [4];
    csr_word_t   tid;
    csr_word_t   estat;
    logic        commit;
    logic        csr_wr;

    assign commit = commit_run & ~stall;
    assign csr_wr = commit & (commit_mode == sub_csrwr || commit_mode == sub_csrxchg);

    assign eentry    = {eentry_q, 6'b0};
    assign tlbrentry = {tlbrentry_q, 6'b0};
    assign estat     = {1'b0, estat_esubcode, estat_ecode, 3'b0, hw_int[8], timer_int,
                        1'b0, hw_int[7:0], estat_is};
    assign ecode     = excp_flush ? estat_ecode : '0;

    // lie bit 10 has no source
    assign int_pending = crmd[2] & |({hw_int[8], timer_int, hw_int[7:0], estat_is} &
                                     {ecfg_lie[12:11], ecfg_lie[9:0]});

    assign tcfg_we     = csr_wr & (commit_addr == csr_tcfg);
    assign tcfg_wdata  = commit_data;
    assign ticlr_pulse = csr_wr & (commit_addr == csr_ticlr) & commit_data[0];

    always_comb
    begin
        case (read_addr)
            csr_crmd:      read_data = {23'b0, crmd};
            csr_prmd:      read_data = {29'b0, prmd};
            csr_euen:      read_data = {31'b0, euen};
            csr_ecfg:      read_data = {19'b0, ecfg_lie};
            csr_estat:     read_data = estat;
            csr_era:       read_data = era;
            csr_badv:      read_data = badv;
            csr_eentry:    read_data = eentry;
            csr_save0, csr_save1, csr_save2, csr_save3:
                read_data = save[read_addr[1:0]];
            csr_tid:       read_data = tid;
            csr_tcfg:      read_data = tcfg;
            csr_tval:      read_data = tval;
            csr_tlbrentry: read_data = tlbrentry;
            default:       read_data = '0;  // ticlr reads as zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= 9'h008;  // direct address mode
            prmd           <= '0;
            euen           <= 1'b0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry_q       <= '0;
            tlbrentry_q    <= '0;
            tid            <= '0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
            excp_flush     <= 1'b0;
            ertn_flush     <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            if (commit && commit_mode == sub_ertn)
            begin
                ertn_flush <= 1'b1;
                crmd[2:0]  <= prmd;
                if (estat_ecode == ecode_tlbr)
                    crmd[4:3] <= 2'b10;  // back to paging
            end
            else if (commit && commit_mode == sub_inte)
            begin
                excp_flush     <= 1'b1;
                prmd           <= crmd[2:0];
                crmd[2:0]      <= '0;
                era            <= commit_pc;
                estat_ecode    <= commit_ecode;
                estat_esubcode <= commit_esubcode;
                if (commit_ecode == ecode_tlbr)
                    crmd[4:3] <= 2'b01;  // refill runs direct mapped
                if (commit_ecode inside {ecode_tlbr, ecode_pil, ecode_pis, ecode_pif,
                                         ecode_pme, ecode_ppi, ecode_ale, ecode_ade})
                    badv <= commit_vaddr;
            end
            else if (csr_wr)
            begin
                case (commit_addr)
                    csr_crmd:
                    begin
                        crmd[2:0] <= commit_data[2:0];
                        crmd[8:5] <= commit_data[8:5];
                        if (commit_data[4] ^ commit_data[3])  // da and pg never both set
                            crmd[4:3] <= commit_data[4:3];
                    end
                    csr_prmd:   prmd     <= commit_data[2:0];
                    csr_euen:   euen     <= commit_data[0];
                    csr_ecfg:   ecfg_lie <= {commit_data[12:11], 1'b0, commit_data[9:0]};
                    csr_estat:  estat_is <= commit_data[1:0];  // software bits only
                    csr_era:    era      <= commit_data;
                    csr_badv:   badv     <= commit_data;
                    csr_eentry: eentry_q <= commit_data[31:6];
                    csr_save0, csr_save1, csr_save2, csr_save3:
                        save[commit_addr[1:0]] <= commit_data;
                    csr_tid:       tid         <= commit_data;
                    csr_tlbrentry: tlbrentry_q <= commit_data[31:6];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_issue.sv
`timescale 1ns/1ps
`default_nettype none

module csr_issue (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush_in,
    input  logic               inst_valid,
    input  logic [3:0]         inst_type,
    input  logic [4:0]         inst_subtype,
    input  csr_pkg::csr_arg_u  inst_arg,
    input  csr_pkg::csr_arg_u  mmu_excp,
    input  csr_pkg::csr_word_t wdata,
    input  csr_pkg::csr_word_t wmask,
    input  csr_pkg::csr_word_t pc0,
    input  csr_pkg::csr_word_t pc1,
    input  csr_pkg::csr_word_t evaddr0,
    input  csr_pkg::csr_word_t evaddr1,
    input  logic               int_pending,
    input  csr_pkg::csr_word_t read_data,
    input  csr_pkg::csr_word_t era,
    input  csr_pkg::csr_word_t eentry,
    input  csr_pkg::csr_word_t tlbrentry,
    output logic               pipe_flush,
    output logic               inte_flush,
    output csr_pkg::csr_word_t redirect_pc,
    output csr_pkg::csr_word_t rdata,
    output logic               commit_run,
    output logic [4:0]         commit_mode,
    output csr_pkg::csr_addr_t commit_addr,
    output csr_pkg::csr_word_t commit_data,
    output logic [5:0]         commit_ecode,
    output logic [8:0]         commit_esubcode,
    output csr_pkg::csr_word_t commit_pc,
    output csr_pkg::csr_word_t commit_vaddr
);
    import csr_pkg::*;

    logic       is_csr;
    logic       inte;
    logic       exe;
    logic       force_run;
    logic       go;
    logic       stop_q;
    logic [4:0] mode;
    logic [5:0] ecode;
    logic [8:0] esubcode;
    csr_word_t  pc;
    csr_word_t  vaddr;
    csr_word_t  mask;
    csr_word_t  wval;
    csr_word_t  target;

    assign is_csr    = inst_type inside {type_priv, type_priv_mmu, type_llscw};
    assign inte      = int_pending & ~stop_q;  // one entry in flight at a time
    assign exe       = (is_csr | inte) & inst_valid;
    assign force_run = mmu_excp.excp.valid & ~inte_flush;  // late exception beats flush_in
    assign go        = (~flush_in & exe) | force_run;

    // late mmu exception first, then interrupt, then the instruction
    always_comb
    begin
        mode     = inst_subtype;
        ecode    = inst_arg.excp.ecode;
        esubcode = inst_arg.excp.esubcode;
        pc       = pc0;
        vaddr    = pc0;  // fetch side faults report the pc
        if (mmu_excp.excp.valid)
        begin
            mode     = sub_inte;
            ecode    = mmu_excp.excp.ecode;
            esubcode = mmu_excp.excp.esubcode;
            pc       = pc1;
            vaddr    = evaddr1;
        end
        else if (inte)
        begin
            mode     = sub_inte;
            ecode    = ecode_int;
            esubcode = '0;
        end
        else if (inst_subtype == sub_inte && inst_arg.excp.ecode == ecode_ale)
            vaddr = evaddr0;
    end

    assign mask = (mode == sub_csrxchg) ? wmask : '1;
    assign wval = (read_data & ~mask) | (wdata & mask);

    always_comb
    begin
        case (mode)
            sub_ertn: target = era;
            sub_inte: target = (ecode == ecode_tlbr) ? tlbrentry : eentry;
            default:  target = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || (flush_in && !stall && !force_run))
        begin
            pipe_flush      <= 1'b0;
            inte_flush      <= 1'b0;
            redirect_pc     <= '0;
            rdata           <= '0;
            commit_run      <= 1'b0;
            commit_mode     <= '0;
            commit_addr     <= '0;
            commit_data     <= '0;
            commit_ecode    <= '0;
            commit_esubcode <= '0;
            commit_pc       <= '0;
            commit_vaddr    <= '0;
            stop_q          <= 1'b0;
        end
        else if (!stall)
        begin
            pipe_flush      <= go & (mode != sub_csrrd);  // plain reads need no refetch
            inte_flush      <= inte & inst_valid & ~mmu_excp.excp.valid;
            redirect_pc     <= target;
            rdata           <= read_data;
            commit_run      <= go;
            commit_mode     <= mode;
            commit_addr     <= inst_arg.csr.num;
            commit_data     <= wval;
            commit_ecode    <= ecode;
            commit_esubcode <= esubcode;
            commit_pc       <= pc;
            commit_vaddr    <= vaddr;
            stop_q          <= go & (mode == sub_inte);
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] csr_word_t;
    typedef logic [13:0]     csr_addr_t;

    // csr numbers
    localparam csr_addr_t csr_crmd      = 14'h0;
    localparam csr_addr_t csr_prmd      = 14'h1;
    localparam csr_addr_t csr_euen      = 14'h2;
    localparam csr_addr_t csr_ecfg      = 14'h4;
    localparam csr_addr_t csr_estat     = 14'h5;
    localparam csr_addr_t csr_era       = 14'h6;
    localparam csr_addr_t csr_badv      = 14'h7;
    localparam csr_addr_t csr_eentry    = 14'hc;
    localparam csr_addr_t csr_save0     = 14'h30;
    localparam csr_addr_t csr_save1     = 14'h31;
    localparam csr_addr_t csr_save2     = 14'h32;
    localparam csr_addr_t csr_save3     = 14'h33;
    localparam csr_addr_t csr_tid       = 14'h40;
    localparam csr_addr_t csr_tcfg      = 14'h41;
    localparam csr_addr_t csr_tval      = 14'h42;
    localparam csr_addr_t csr_ticlr     = 14'h44;
    localparam csr_addr_t csr_tlbrentry = 14'h88;

    // instruction types on the csr path
    localparam logic [3:0] type_priv     = 4'd3;
    localparam logic [3:0] type_llscw    = 4'd6;
    localparam logic [3:0] type_priv_mmu = 4'd10;

    localparam logic [4:0] sub_inte    = 5'd0;  // exception or interrupt entry
    localparam logic [4:0] sub_ertn    = 5'd6;
    localparam logic [4:0] sub_csrrd   = 5'd8;
    localparam logic [4:0] sub_csrwr   = 5'd9;
    localparam logic [4:0] sub_csrxchg = 5'd10;

    localparam logic [5:0] ecode_int  = 6'h0;
    localparam logic [5:0] ecode_pil  = 6'h1;
    localparam logic [5:0] ecode_pis  = 6'h2;
    localparam logic [5:0] ecode_pif  = 6'h3;
    localparam logic [5:0] ecode_pme  = 6'h4;
    localparam logic [5:0] ecode_ppi  = 6'h7;
    localparam logic [5:0] ecode_ade  = 6'h8;
    localparam logic [5:0] ecode_ale  = 6'h9;
    localparam logic [5:0] ecode_sys  = 6'hb;
    localparam logic [5:0] ecode_brk  = 6'hc;
    localparam logic [5:0] ecode_ine  = 6'hd;
    localparam logic [5:0] ecode_tlbr = 6'h3f;

    typedef struct packed {
        logic       valid;
        logic [8:0] esubcode;
        logic [5:0] ecode;
    } excp_info_t;

    // csr number for csr instructions, exception info otherwise
    typedef union packed {
        excp_info_t excp;
        struct packed {
            logic [1:0] pad;
            csr_addr_t  num;
        } csr;
    } csr_arg_u;

endpackage

`default_nettype wire

//--- logic/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer #(
    parameter int timer_n = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tcfg_we,
    input  csr_pkg::csr_word_t tcfg_wdata,
    input  logic               ticlr_pulse,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic               timer_int
);
    import csr_pkg::*;

    logic [timer_n-1:0] cfg_q;   // bit 0 enable, bit 1 periodic
    logic [timer_n-1:0] cnt_q;
    logic               changed; // cfg written last cycle
    logic               at_zero;

    assign at_zero = (cnt_q == '0);
    assign tcfg    = csr_word_t'(cfg_q);
    assign tval    = csr_word_t'(cnt_q);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            cfg_q     <= '0;
            cnt_q     <= '0;
            changed   <= 1'b0;
            timer_int <= 1'b0;
        end
        else
        begin
            changed <= tcfg_we;
            if (tcfg_we)
                cfg_q <= tcfg_wdata[timer_n-1:0];

            if (ticlr_pulse)
                timer_int <= 1'b0;
            else if (at_zero && cfg_q[0] && !changed)
                timer_int <= 1'b1;

            if ((at_zero && cfg_q[1]) || (cfg_q[0] && changed))
                cnt_q <= {cfg_q[timer_n-1:2], 2'b0};
            else if (!cfg_q[0])
                cnt_q <= '0;
            else if (cnt_q != '1)
                cnt_q <= cnt_q - timer_n'(1);  // one shot parks at all ones
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter int timer_n = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush_in,
    input  logic               inst_valid,
    input  logic [3:0]         inst_type,
    input  logic [4:0]         inst_subtype,
    input  csr_pkg::csr_arg_u  inst_arg,
    input  csr_pkg::csr_arg_u  mmu_excp,
    input  csr_pkg::csr_word_t wdata,
    input  csr_pkg::csr_word_t wmask,
    input  csr_pkg::csr_word_t pc0,
    input  csr_pkg::csr_word_t pc1,
    input  csr_pkg::csr_word_t evaddr0,
    input  csr_pkg::csr_word_t evaddr1,
    input  logic [8:0]         hw_int,
    output logic               pipe_flush,
    output logic               inte_flush,
    output csr_pkg::csr_word_t redirect_pc,
    output csr_pkg::csr_word_t rdata,
    output logic [8:0]         crmd,
    output logic               excp_flush,
    output logic               ertn_flush,
    output logic [5:0]         ecode
);
    import csr_pkg::*;

    logic       commit_run;
    logic [4:0] commit_mode;
    csr_addr_t  commit_addr;
    csr_word_t  commit_data;
    logic [5:0] commit_ecode;
    logic [8:0] commit_esubcode;
    csr_word_t  commit_pc;
    csr_word_t  commit_vaddr;
    csr_word_t  read_data;
    logic       int_pending;
    csr_word_t  era;
    csr_word_t  eentry;
    csr_word_t  tlbrentry;
    logic       tcfg_we;
    csr_word_t  tcfg_wdata;
    logic       ticlr_pulse;
    csr_word_t  tcfg;
    csr_word_t  tval;
    logic       timer_int;

    csr_issue u_issue (
        .clk             (clk),
        .rstn            (rstn),
        .stall           (stall),
        .flush_in        (flush_in),
        .inst_valid      (inst_valid),
        .inst_type       (inst_type),
        .inst_subtype    (inst_subtype),
        .inst_arg        (inst_arg),
        .mmu_excp        (mmu_excp),
        .wdata           (wdata),
        .wmask           (wmask),
        .pc0             (pc0),
        .pc1             (pc1),
        .evaddr0         (evaddr0),
        .evaddr1         (evaddr1),
        .int_pending     (int_pending),
        .read_data       (read_data),
        .era             (era),
        .eentry          (eentry),
        .tlbrentry       (tlbrentry),
        .pipe_flush      (pipe_flush),
        .inte_flush      (inte_flush),
        .redirect_pc     (redirect_pc),
        .rdata           (rdata),
        .commit_run      (commit_run),
        .commit_mode     (commit_mode),
        .commit_addr     (commit_addr),
        .commit_data     (commit_data),
        .commit_ecode    (commit_ecode),
        .commit_esubcode (commit_esubcode),
        .commit_pc       (commit_pc),
        .commit_vaddr    (commit_vaddr)
    );

    csr_file u_file (
        .clk             (clk),
        .rstn            (rstn),
        .commit_run      (commit_run),
        .stall           (stall),
        .commit_mode     (commit_mode),
        .commit_addr     (commit_addr),
        .commit_data     (commit_data),
        .commit_ecode    (commit_ecode),
        .commit_esubcode (commit_esubcode),
        .commit_pc       (commit_pc),
        .commit_vaddr    (commit_vaddr),
        .hw_int          (hw_int),
        .tcfg            (tcfg),
        .tval            (tval),
        .timer_int       (timer_int),
        .read_addr       (inst_arg.csr.num),
        .read_data       (read_data),
        .int_pending     (int_pending),
        .era             (era),
        .eentry          (eentry),
        .tlbrentry       (tlbrentry),
        .crmd            (crmd),
        .excp_flush      (excp_flush),
        .ertn_flush      (ertn_flush),
        .ecode           (ecode),
        .tcfg_we         (tcfg_we),
        .tcfg_wdata      (tcfg_wdata),
        .ticlr_pulse     (ticlr_pulse)
    );

    csr_timer #(
        .timer_n (timer_n)
    ) u_timer (
        .clk         (clk),
        .rstn        (rstn),
        .tcfg_we     (tcfg_we),
        .tcfg_wdata  (tcfg_wdata),
        .ticlr_pulse (ticlr_pulse),
        .tcfg        (tcfg),
        .tval        (tval),
        .timer_int   (timer_int)
    );

endmodule

`default_nettype wire

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    logic       clk;
    logic       rstn;
    logic       stall;
    logic       flush_in;
    logic       inst_valid;
    logic [3:0] inst_type;
    logic [4:0] inst_subtype;
    csr_arg_u   inst_arg;
    csr_arg_u   mmu_excp;
    csr_word_t  wdata;
    csr_word_t  wmask;
    csr_word_t  pc0;
    csr_word_t  pc1;
    csr_word_t  evaddr0;
    csr_word_t  evaddr1;
    logic [8:0] hw_int;
    logic       pipe_flush;
    logic       inte_flush;
    csr_word_t  redirect_pc;
    csr_word_t  rdata;
    logic [8:0] crmd;
    logic       excp_flush;
    logic       ertn_flush;
    logic [5:0] ecode;

    logic [31:0] lfsr_q;
    int          errors;
    int          test_no;
    int          test_errors;
    int          passed;
    int          failed;
    string       test_name;
    logic        seen_flush;  // outputs one cycle after issue
    csr_word_t   seen_target;
    csr_word_t   seen_rdata;
    csr_word_t   save_val [4];

    csr_unit #(
        .timer_n (32)
    ) u_csr_unit (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            w      = {w[30:0], lfsr_q[0]};
        end
        return w;
    endfunction

    task automatic record_failure(input string msg);
        errors++;
        $display("error %s: %s", test_name, msg);
    endtask

    task automatic abort_run(input string why);
        $display("%s: %s", test_name, why);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_word(input string what, input csr_word_t exp, input csr_word_t act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("error %s: %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // drive one slot, capture the registered outputs, go idle
    task automatic issue(input logic [3:0] ty, input logic [4:0] sub, input logic [15:0] arg,
                         input csr_word_t wd, input csr_word_t wm, input csr_word_t pc);
        inst_valid   = 1'b1;
        inst_type    = ty;
        inst_subtype = sub;
        inst_arg     = arg;
        wdata        = wd;
        wmask        = wm;
        pc0          = pc;
        @(posedge clk);
        @(negedge clk);
        seen_flush   = pipe_flush;
        seen_target  = redirect_pc;
        seen_rdata   = rdata;
        inst_valid   = 1'b0;
        inst_type    = '0;
        inst_subtype = '0;
        inst_arg     = '0;
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_word_t value);
        issue(type_priv, sub_csrwr, {2'b00, addr}, value, '0, 32'h1c00_0000);
        idle(2);
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_word_t value);
        issue(type_priv, sub_csrrd, {2'b00, addr}, '0, '0, 32'h1c00_0004);
        idle(2);
        value = seen_rdata;
    endtask

    task automatic wait_flag(input int sel, input string what);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < 100)
        begin
            @(negedge clk);
            case (sel)
                0:       hit = excp_flush;
                1:       hit = ertn_flush;
                default: hit = inte_flush;
            endcase
            n++;
        end
        if (!hit)
            abort_run($sformatf("timed out waiting for %s", what));
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        test_no++;
        if (errors == test_errors)
        begin
            passed++;
            $display("test %0d %s: ok", test_no, test_name);
        end
        else
        begin
            failed++;
            $display("test %0d %s: %0d errors", test_no, test_name, errors - test_errors);
        end
    endtask

    assert property (@(posedge clk) disable iff (!rstn) excp_flush |=> !excp_flush)
    else record_failure("excp_flush stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (!rstn) ertn_flush |=> !ertn_flush)
    else record_failure("ertn_flush stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (!rstn) !excp_flush |-> ecode == 6'd0)
    else record_failure("ecode was not zero outside the excp_flush pulse");
    assert property (@(posedge clk) disable iff (!rstn) inte_flush |-> pipe_flush)
    else record_failure("inte_flush came without pipe_flush");
    assert property (@(posedge clk) disable iff (!rstn)
                     stall |=> $stable(pipe_flush) && $stable(redirect_pc) && $stable(rdata))
    else record_failure("issue outputs moved while stall was high");

    initial
    begin
        csr_word_t v;
        csr_word_t w;
        csr_word_t m;
        csr_word_t eentry_v;
        csr_word_t tlbr_v;
        csr_word_t pc_v;
        csr_word_t va_v;
        lfsr_q       = 32'h704f4507;
        errors       = 0;
        test_no      = 0;
        passed       = 0;
        failed       = 0;
        test_name    = "setup";
        rstn         = 1'b0;
        stall        = 1'b0;
        flush_in     = 1'b0;
        inst_valid   = 1'b0;
        inst_type    = '0;
        inst_subtype = '0;
        inst_arg     = '0;
        mmu_excp     = '0;
        wdata        = '0;
        wmask        = '0;
        pc0          = '0;
        pc1          = '0;
        evaddr0      = '0;
        evaddr1      = '0;
        hw_int       = '0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        start_test("reset");
        check_word("flush outputs", 32'h0,
                   {28'd0, pipe_flush, inte_flush, excp_flush, ertn_flush});
        check_word("redirect_pc", 32'h0, redirect_pc);
        check_word("rdata", 32'h0, rdata);
        read_csr(csr_crmd, v);
        check_word("crmd", 32'h8, v);
        read_csr(csr_save0, v);
        check_word("save0", 32'h0, v);
        end_test();

        start_test("csr read write");
        for (int i = 0; i < 4; i++)
        begin
            save_val[i] = rand_word();
            write_csr(csr_save0 + csr_addr_t'(i), save_val[i]);
            check_bit("pipe_flush after csrwr", 1'b1, seen_flush);
        end
        for (int i = 0; i < 4; i++)
        begin
            read_csr(csr_save0 + csr_addr_t'(i), v);
            check_word($sformatf("save%0d", i), save_val[i], v);
            check_bit("pipe_flush after csrrd", 1'b0, seen_flush);
        end
        w = rand_word();
        write_csr(csr_tid, w);
        read_csr(csr_tid, v);
        check_word("tid", w, v);
        w = rand_word();
        m = rand_word();
        issue(type_priv, sub_csrxchg, {2'b00, csr_save3}, w, m, 32'h1c00_0010);
        idle(2);
        check_word("csrxchg old value", save_val[3], seen_rdata);
        save_val[3] = (save_val[3] & ~m) | (w & m);
        read_csr(csr_save3, v);
        check_word("save3 after csrxchg", save_val[3], v);
        end_test();

        start_test("exception and ertn");
        w = rand_word();
        write_csr(csr_eentry, w);
        eentry_v = {w[31:6], 6'b0};
        write_csr(csr_crmd, 32'hf);  // plv 3, ie, da
        check_word("crmd", 32'hf, {23'd0, crmd});
        w    = rand_word();
        pc_v = {w[31:2], 2'b00};
        issue(type_priv, sub_inte, {1'b1, 9'd0, ecode_sys}, '0, '0, pc_v);
        check_word("redirect_pc", eentry_v, seen_target);
        wait_flag(0, "excp_flush");
        check_word("ecode", 32'hb, {26'd0, ecode});
        idle(2);
        read_csr(csr_era, v);
        check_word("era", pc_v, v);
        read_csr(csr_prmd, v);
        check_word("prmd", 32'h7, v);
        issue(type_priv, sub_ertn, 16'h0, '0, '0, 32'h1c00_0020);
        check_word("ertn redirect_pc", pc_v, seen_target);
        wait_flag(1, "ertn_flush");
        idle(2);
        check_word("crmd after ertn", 32'hf, {23'd0, crmd});
        end_test();

        start_test("tlb refill");
        w = rand_word();
        write_csr(csr_tlbrentry, w);
        tlbr_v   = {w[31:6], 6'b0};
        va_v     = rand_word();
        w        = rand_word();
        pc1      = {w[31:2], 2'b00};
        evaddr1  = va_v;
        mmu_excp = {1'b1, 9'd0, ecode_tlbr};  // late fault beats the csrwr
        issue(type_priv, sub_csrwr, {2'b00, csr_save2}, rand_word(), '0, 32'h1c00_0030);
        mmu_excp = '0;
        check_word("redirect_pc", tlbr_v, seen_target);
        wait_flag(0, "excp_flush");
        check_word("ecode", 32'h3f, {26'd0, ecode});
        idle(2);
        read_csr(csr_badv, v);
        check_word("badv", va_v, v);
        read_csr(csr_save2, v);
        check_word("save2 untouched", save_val[2], v);
        check_word("crmd in refill", 32'h8, {23'd0, crmd});
        issue(type_priv, sub_ertn, 16'h0, '0, '0, 32'h1c00_0040);
        check_word("ertn redirect_pc", pc1, seen_target);
        wait_flag(1, "ertn_flush");
        idle(2);
        check_word("crmd after ertn", 32'h17, {23'd0, crmd});  // pg back, da off
        end_test();

        start_test("timer interrupt");
        write_csr(csr_ecfg, 32'h800);
        write_csr(csr_crmd, 32'hc);
        write_csr(csr_tcfg, 32'h11);  // initval 0x10, one shot
        inst_valid = 1'b1;            // interrupt needs a valid slot
        pc0        = 32'h1c00_0050;
        wait_flag(2, "inte_flush");
        check_word("redirect_pc", eentry_v, redirect_pc);
        inst_valid = 1'b0;
        wait_flag(0, "excp_flush");
        check_word("ecode", 32'h0, {26'd0, ecode});
        idle(2);
        read_csr(csr_estat, v);
        check_bit("estat timer bit", 1'b1, v[11]);
        write_csr(csr_ticlr, 32'h1);
        read_csr(csr_estat, v);
        check_bit("estat timer bit after ticlr", 1'b0, v[11]);
        end_test();

        start_test("flush and stall");
        w        = rand_word();
        flush_in = 1'b1;
        issue(type_priv, sub_csrwr, {2'b00, csr_save1}, w, '0, 32'h1c00_0060);
        flush_in = 1'b0;
        check_bit("pipe_flush under flush_in", 1'b0, seen_flush);
        idle(2);
        read_csr(csr_save1, v);
        check_word("save1 kept", save_val[1], v);
        issue(type_priv, sub_csrwr, {2'b00, csr_crmd}, 32'h9, '0, 32'h1c00_0070);
        stall = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            check_word("crmd during stall", 32'h8, {23'd0, crmd});
        end
        stall = 1'b0;
        @(negedge clk);
        check_word("crmd after stall", 32'h9, {23'd0, crmd});
        idle(2);
        end_test();

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
